// ==== verilog/eth_ctrl_consts.svh ====
/*
 * Shared sizes, register offsets and ID value for the management controller.
 * Offsets are byte addresses and are decoded exactly, so no aliasing.
 */
`ifndef ETH_CTRL_CONSTS_SVH
`define ETH_CTRL_CONSTS_SVH

// transceiver ports served
`define ETH_NUM_PORTS   4

// bus geometry, shared by AXI4-Lite and Avalon-MM
`define ETH_ADDR_W      16
`define ETH_DATA_W      32
`define ETH_STRB_W      4

// flops per synchronizer chain
`define ETH_SYNC_STAGES 3

// register map
`define ETH_REG_ID      16'h0000
`define ETH_REG_SCRATCH 16'h0004
`define ETH_REG_STATUS  16'h0008
`define ETH_REG_STICKY  16'h000C
`define ETH_ID_VALUE    32'h4554_0104

`endif

// ==== verilog/eth_ctrl_bus_pkg.sv ====
/*
 * AXI4-Lite channel structs and the internal Avalon-MM command/response.
 * No waitrequest on the Avalon side, the register file never stalls.
 */
`include "eth_ctrl_consts.svh"

package eth_ctrl_bus_pkg;

    // AXI response codes, EXOKAY and DECERR unused
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // --------------------------------------------------
    // AXI4-Lite channels
    // --------------------------------------------------
    typedef struct packed {
        logic [`ETH_ADDR_W-1:0] addr;
        logic                   valid;
    } axi_aw_t;

    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        logic [`ETH_STRB_W-1:0] strb;
        logic                   valid;
    } axi_w_t;

    typedef struct packed {
        logic [`ETH_ADDR_W-1:0] addr;
        logic                   valid;
    } axi_ar_t;

    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   valid;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
        logic      valid;
    } axi_b_t;

    // readies back toward the master
    typedef struct packed {
        logic aw;
        logic w;
        logic ar;
    } axi_ready_t;

    // --------------------------------------------------
    // Avalon-MM, bridge to register file
    // --------------------------------------------------
    typedef struct packed {
        logic [`ETH_ADDR_W-1:0] address;
        logic                   read;
        logic                   write;
        logic [`ETH_DATA_W-1:0] writedata;
        logic [`ETH_STRB_W-1:0] byteenable;
    } avmm_cmd_t;

    typedef struct packed {
        logic                   readdatavalid;
        logic                   writeresponsevalid;
        axi_resp_e              response;
        logic [`ETH_DATA_W-1:0] readdata;
    } avmm_rsp_t;

endpackage

// ==== verilog/eth_ctrl_port_pkg.sv ====
/*
 * Per-port link status and the all-port summary.
 * Summary field order matches port_status_t so the two cast freely.
 */
`include "eth_ctrl_consts.svh"

package eth_ctrl_port_pkg;

    // msb first, this is also the STATUS nibble order
    typedef struct packed {
        logic rx_pcs_ready;
        logic tx_lanes_stable;
        logic cdr_lock;
        logic tx_pll_locked;
    } port_status_t;

    // port p sits at bits 4p+3..4p
    typedef port_status_t [`ETH_NUM_PORTS-1:0] port_status_vec_t;

    // AND of each field over all ports
    typedef struct packed {
        logic rx_pcs_ready;
        logic tx_lanes_stable;
        logic cdr_lock;
        logic tx_pll_locked;
    } link_summary_t;

endpackage

// ==== verilog/reconfig_reset_seq.sv ====
/*
 * Reconfiguration reset sequencer. After i_rst the reset is held until all
 * tx lanes report stable. i_soft_reset may be asynchronous, it is resynced.
 */
`include "eth_ctrl_consts.svh"

module reconfig_reset_seq (
    input  logic i_reconfig_clk,
    input  logic i_rst,
    input  logic i_soft_reset,
    input  logic i_lanes_stable_all,
    output logic o_reconfig_reset
);

    // soft reset resync chain, comes out of reset asserted
    logic [`ETH_SYNC_STAGES-1:0] soft_sync_q;
    // power-up hold until the lanes settle
    logic                        hold_q;

    always_ff @(posedge i_reconfig_clk) begin
        if (i_rst) begin
            soft_sync_q <= '1;
        end else begin
            soft_sync_q <= {soft_sync_q[`ETH_SYNC_STAGES-2:0], i_soft_reset};
        end
    end

    // lanes stable bit is already synchronized upstream
    always_ff @(posedge i_reconfig_clk) begin
        if (i_rst) begin
            hold_q <= 1'b1;
        end else if (i_lanes_stable_all) begin
            hold_q <= 1'b0;
        end
    end

    assign o_reconfig_reset = soft_sync_q[`ETH_SYNC_STAGES-1] | hold_q;

    // bus reset must follow a power-on reset without a gap
    a_reset_follows_rst: assert property (
        @(posedge i_reconfig_clk) i_rst |=> o_reconfig_reset
    ) else $error("reconfig reset low right after i_rst");

endmodule

// ==== verilog/port_status_sync.sv ====
/*
 * Brings per-port status into the reconfig clock domain.
 * Each bit is resynced on its own, so a multi-bit change may land over two
 * cycles. Sticky loss-of-lock bits are set on a falling synced cdr_lock.
 */
`include "eth_ctrl_consts.svh"

module port_status_sync
    import eth_ctrl_port_pkg::*;
(
    input  logic                      i_reconfig_clk,
    input  logic                      i_rst,
    input  port_status_vec_t          i_port_status,
    input  logic [`ETH_NUM_PORTS-1:0] i_sticky_clr,
    output port_status_vec_t          o_status,
    output link_summary_t             o_summary,
    output logic                      o_lanes_stable_all,
    output logic [`ETH_NUM_PORTS-1:0] o_sticky_lol
);

    // --------------------------------------------------
    // synchronizer chains
    // --------------------------------------------------
    port_status_vec_t [`ETH_SYNC_STAGES-1:0] sync_q;

    // cleared so nothing looks stable or locked out of reset
    always_ff @(posedge i_reconfig_clk) begin
        if (i_rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`ETH_SYNC_STAGES-2:0], i_port_status};
        end
    end

    assign o_status = sync_q[`ETH_SYNC_STAGES-1];

    // per field AND over the ports
    always_comb begin
        o_summary = '1;
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            o_summary = o_summary & link_summary_t'(o_status[p]);
        end
    end

    assign o_lanes_stable_all = o_summary.tx_lanes_stable;

    // --------------------------------------------------
    // sticky loss of CDR lock
    // --------------------------------------------------
    logic [`ETH_NUM_PORTS-1:0] cdr_q;
    logic [`ETH_NUM_PORTS-1:0] cdr_now;
    logic [`ETH_NUM_PORTS-1:0] cdr_fell;

    always_comb begin
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            cdr_now[p] = o_status[p].cdr_lock;
        end
    end

    assign cdr_fell = cdr_q & ~cdr_now;

    // a new loss beats a clear in the same cycle
    always_ff @(posedge i_reconfig_clk) begin
        if (i_rst) begin
            cdr_q        <= '0;
            o_sticky_lol <= '0;
        end else begin
            cdr_q        <= cdr_now;
            o_sticky_lol <= (o_sticky_lol & ~i_sticky_clr) | cdr_fell;
        end
    end

    // a flag only drops after a clear pulse from the register file
    a_sticky_needs_clr: assert property (
        @(posedge i_reconfig_clk) disable iff (i_rst)
        !$past(i_rst) |->
            (($past(o_sticky_lol) & ~o_sticky_lol & ~$past(i_sticky_clr)) == '0)
    ) else $error("sticky bit cleared without a clear pulse");

endmodule

// ==== verilog/axi_lite_avmm_bridge.sv ====
/*
 * AXI4-Lite slave to Avalon-MM master, one transaction in flight.
 * Reads win over writes when both wait. Readies are registered, so an
 * address is taken one cycle after its valid at the earliest.
 */
`include "eth_ctrl_consts.svh"

module axi_lite_avmm_bridge
    import eth_ctrl_bus_pkg::*;
(
    input  logic       i_reconfig_clk,
    input  logic       i_bus_reset,
    input  axi_aw_t    i_aw,
    input  axi_w_t     i_w,
    input  axi_ar_t    i_ar,
    input  logic       i_rready,
    input  logic       i_bready,
    output axi_ready_t o_ready,
    output axi_r_t     o_r,
    output axi_b_t     o_b,
    output avmm_cmd_t  o_cmd,
    input  avmm_rsp_t  i_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e                 state_q;
    axi_ready_t             ready_q;

    // latched request and captured response
    logic                   is_write_q;
    logic [`ETH_ADDR_W-1:0] addr_q;
    logic [`ETH_DATA_W-1:0] wdata_q;
    logic [`ETH_STRB_W-1:0] strb_q;
    logic [`ETH_DATA_W-1:0] rdata_q;
    axi_resp_e              resp_q;

    logic ar_hs;
    logic aw_hs;
    logic rsp_valid;
    logic resp_done;

    // aw and w readies always rise together
    assign ar_hs     = i_ar.valid & ready_q.ar;
    assign aw_hs     = i_aw.valid & i_w.valid & ready_q.aw & ready_q.w;
    assign rsp_valid = i_rsp.readdatavalid | i_rsp.writeresponsevalid;
    assign resp_done = is_write_q ? i_bready : i_rready;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge i_reconfig_clk) begin
        if (i_bus_reset) begin
            state_q <= ST_IDLE;
            ready_q <= '0;
        end else begin
            // readies are single cycle pulses
            ready_q <= '0;
            case (state_q)
                ST_IDLE: begin
                    if (ar_hs || aw_hs) begin
                        state_q <= ST_ISSUE;
                    end else if (ready_q == '0) begin
                        if (i_ar.valid) begin
                            ready_q.ar <= 1'b1;
                        end else if (i_aw.valid && i_w.valid) begin
                            ready_q.aw <= 1'b1;
                            ready_q.w  <= 1'b1;
                        end
                    end
                end
                // one Avalon cycle
                ST_ISSUE: state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (rsp_valid) begin
                        state_q <= ST_RESP;
                    end
                end
                // hold r/b valid until the master takes it
                ST_RESP: begin
                    if (resp_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // request and response registers
    // --------------------------------------------------
    always_ff @(posedge i_reconfig_clk) begin
        if (ar_hs) begin
            is_write_q <= 1'b0;
            addr_q     <= i_ar.addr;
            strb_q     <= '1;
        end else if (aw_hs) begin
            is_write_q <= 1'b1;
            addr_q     <= i_aw.addr;
            wdata_q    <= i_w.data;
            strb_q     <= i_w.strb;
        end
        if (state_q == ST_WAIT && rsp_valid) begin
            rdata_q <= i_rsp.readdata;
            resp_q  <= i_rsp.response;
        end
    end

    assign o_ready = ready_q;

    always_comb begin
        o_cmd.address    = addr_q;
        o_cmd.read       = (state_q == ST_ISSUE) & ~is_write_q;
        o_cmd.write      = (state_q == ST_ISSUE) & is_write_q;
        o_cmd.writedata  = wdata_q;
        o_cmd.byteenable = strb_q;
    end

    always_comb begin
        o_r.data  = rdata_q;
        o_r.resp  = resp_q;
        o_r.valid = (state_q == ST_RESP) & ~is_write_q;
        o_b.resp  = resp_q;
        o_b.valid = (state_q == ST_RESP) & is_write_q;
    end

    a_cmd_onehot: assert property (
        @(posedge i_reconfig_clk) disable iff (i_bus_reset)
        !(o_cmd.read && o_cmd.write)
    ) else $error("avalon read and write issued together");

    // read data must not move under back-pressure
    a_rvalid_hold: assert property (
        @(posedge i_reconfig_clk) disable iff (i_bus_reset)
        o_r.valid && !i_rready |=> o_r.valid && $stable(o_r.data) && $stable(o_r.resp)
    ) else $error("rvalid or read data changed before rready");

endmodule

// ==== verilog/port_csr.sv ====
/*
 * Avalon-MM register file: ID, SCRATCH, STATUS, STICKY.
 * Answers every command in the following cycle. Unmapped offsets give
 * SLVERR with zero data, writes to read-only registers are dropped.
 */
`include "eth_ctrl_consts.svh"

module port_csr
    import eth_ctrl_bus_pkg::*;
    import eth_ctrl_port_pkg::*;
(
    input  logic                      i_reconfig_clk,
    input  logic                      i_bus_reset,
    input  avmm_cmd_t                 i_cmd,
    output avmm_rsp_t                 o_rsp,
    input  port_status_vec_t          i_status,
    input  link_summary_t             i_summary,
    input  logic [`ETH_NUM_PORTS-1:0] i_sticky_lol,
    output logic [`ETH_NUM_PORTS-1:0] o_sticky_clr
);

    logic [`ETH_DATA_W-1:0] scratch_q;
    logic                   rvalid_q;
    logic                   wvalid_q;
    axi_resp_e              resp_q;
    logic [`ETH_DATA_W-1:0] rdata_q;

    logic [`ETH_DATA_W-1:0] rd_data;
    logic                   hit;

    // --------------------------------------------------
    // decode and read mux
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        hit     = 1'b1;
        case (i_cmd.address)
            `ETH_REG_ID:      rd_data = `ETH_ID_VALUE;
            `ETH_REG_SCRATCH: rd_data = scratch_q;
            `ETH_REG_STATUS: begin
                // summary low, then one nibble per port from bit 8
                rd_data[3:0] = i_summary;
                for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
                    rd_data[8+4*p +: 4] = i_status[p];
                end
            end
            `ETH_REG_STICKY:  rd_data[`ETH_NUM_PORTS-1:0] = i_sticky_lol;
            default:          hit = 1'b0;
        endcase
    end

    // write one to clear, low byte lane carries the flags
    assign o_sticky_clr = (i_cmd.write && i_cmd.address == `ETH_REG_STICKY
                           && i_cmd.byteenable[0])
                          ? i_cmd.writedata[`ETH_NUM_PORTS-1:0] : '0;

    // --------------------------------------------------
    // scratch and response handshake
    // --------------------------------------------------
    always_ff @(posedge i_reconfig_clk) begin
        if (i_bus_reset) begin
            scratch_q <= '0;
            rvalid_q  <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= i_cmd.read;
            wvalid_q <= i_cmd.write;
            if (i_cmd.write && i_cmd.address == `ETH_REG_SCRATCH) begin
                // byte merge under the strobes
                for (int b = 0; b < `ETH_STRB_W; b++) begin
                    if (i_cmd.byteenable[b]) begin
                        scratch_q[8*b +: 8] <= i_cmd.writedata[8*b +: 8];
                    end
                end
            end
        end
    end

    // response payload, only looked at with a valid
    always_ff @(posedge i_reconfig_clk) begin
        resp_q  <= hit ? RESP_OKAY : RESP_SLVERR;
        rdata_q <= rd_data;
    end

    always_comb begin
        o_rsp.readdatavalid      = rvalid_q;
        o_rsp.writeresponsevalid = wvalid_q;
        o_rsp.response           = resp_q;
        o_rsp.readdata           = rdata_q;
    end

endmodule

// ==== verilog/eth_ctrl_top.sv ====
/*
 * Management-plane controller top, all logic on i_reconfig_clk.
 * i_soft_reset and i_port_status may be asynchronous to it.
 */
`include "eth_ctrl_consts.svh"

module eth_ctrl_top
    import eth_ctrl_bus_pkg::*;
    import eth_ctrl_port_pkg::*;
(
    input  logic             i_reconfig_clk,
    input  logic             i_rst,
    input  logic             i_soft_reset,
    input  port_status_vec_t i_port_status,
    input  axi_aw_t          i_aw,
    input  axi_w_t           i_w,
    input  axi_ar_t          i_ar,
    input  logic             i_rready,
    input  logic             i_bready,
    output axi_ready_t       o_ready,
    output axi_r_t           o_r,
    output axi_b_t           o_b,
    output logic             o_reconfig_reset
);

    port_status_vec_t          status_sync;
    link_summary_t             summary;
    logic                      lanes_stable_all;
    logic [`ETH_NUM_PORTS-1:0] sticky_lol;
    logic [`ETH_NUM_PORTS-1:0] sticky_clr;
    avmm_cmd_t                 avmm_cmd;
    avmm_rsp_t                 avmm_rsp;

    // --------------------------------------------------
    // reset and status fan-in
    // --------------------------------------------------
    reconfig_reset_seq u_reconfig_reset_seq (
        .i_reconfig_clk     (i_reconfig_clk),
        .i_rst              (i_rst),
        .i_soft_reset       (i_soft_reset),
        .i_lanes_stable_all (lanes_stable_all),
        .o_reconfig_reset   (o_reconfig_reset)
    );

    port_status_sync u_port_status_sync (
        .i_reconfig_clk     (i_reconfig_clk),
        .i_rst              (i_rst),
        .i_port_status      (i_port_status),
        .i_sticky_clr       (sticky_clr),
        .o_status           (status_sync),
        .o_summary          (summary),
        .o_lanes_stable_all (lanes_stable_all),
        .o_sticky_lol       (sticky_lol)
    );

    // --------------------------------------------------
    // bus path, held in reset by the sequencer
    // --------------------------------------------------
    axi_lite_avmm_bridge u_axi_lite_avmm_bridge (
        .i_reconfig_clk (i_reconfig_clk),
        .i_bus_reset    (o_reconfig_reset),
        .i_aw           (i_aw),
        .i_w            (i_w),
        .i_ar           (i_ar),
        .i_rready       (i_rready),
        .i_bready       (i_bready),
        .o_ready        (o_ready),
        .o_r            (o_r),
        .o_b            (o_b),
        .o_cmd          (avmm_cmd),
        .i_rsp          (avmm_rsp)
    );

    port_csr u_port_csr (
        .i_reconfig_clk (i_reconfig_clk),
        .i_bus_reset    (o_reconfig_reset),
        .i_cmd          (avmm_cmd),
        .o_rsp          (avmm_rsp),
        .i_status       (status_sync),
        .i_summary      (summary),
        .i_sticky_lol   (sticky_lol),
        .o_sticky_clr   (sticky_clr)
    );

endmodule

// ==== sim/tb_eth_ctrl_checker.sv ====
/*
 * Scoreboard. Steps through the stim file in the same order as the driver,
 * one record per completed R, B or idle mark. Samples on the falling edge.
 */
`include "eth_ctrl_consts.svh"

module tb_eth_ctrl_checker
    import eth_ctrl_bus_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reconfig_reset,
    input  axi_ready_t i_ready,
    input  axi_r_t     i_r,
    input  axi_b_t     i_b,
    input  logic       i_rready,
    input  logic       i_bready,
    input  logic       i_idle_mark,
    input  logic       i_finish,
    output int         o_errors,
    output int         o_checks
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_W    = 8;
    localparam int MAX_REC  = 64;
    localparam int OP_IDLE  = 0;
    localparam int OP_READ  = 1;
    localparam int OP_WRITE = 2;

    logic [31:0] stim [0:REC_W*MAX_REC-1];
    int          rec    = 0;
    int          errors = 0;
    int          checks = 0;
    logic        r_held = 1'b0;
    logic        b_held = 1'b0;
    logic        done   = 1'b0;
    axi_r_t      r_last;
    axi_b_t      b_last;

    assign o_errors = errors;
    assign o_checks = checks;

    initial begin
        $readmemh("sim/eth_ctrl_stim.txt", stim);
    end

    // past the table reads as an invalid op
    function automatic logic [31:0] field(input int idx, input int k);
        if (idx >= MAX_REC) begin
            return '1;
        end
        return stim[REC_W*idx + k];
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // --------------------------------------------------
    // per record compares
    // --------------------------------------------------
    task automatic check_read();
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic [31:0] exp_resp;
        addr     = field(rec, 1);
        exp_data = field(rec, 6);
        exp_resp = field(rec, 7);
        if (field(rec, 0) != OP_READ) begin
            report_problem($sformatf("read response but record %0d is no read", rec));
        end else begin
            checks++;
            if (i_r.data != exp_data || i_r.resp != exp_resp[1:0]) begin
                report_mismatch($sformatf("read %04h got %08h resp %0d, expected %08h resp %0d",
                                addr[15:0], i_r.data, i_r.resp, exp_data, exp_resp[1:0]));
            end
            rec++;
        end
    endtask

    task automatic check_write();
        logic [31:0] addr;
        logic [31:0] exp_resp;
        addr     = field(rec, 1);
        exp_resp = field(rec, 7);
        if (field(rec, 0) != OP_WRITE) begin
            report_problem($sformatf("write response but record %0d is no write", rec));
        end else begin
            checks++;
            if (i_b.resp != exp_resp[1:0]) begin
                report_mismatch($sformatf("write %04h got resp %0d, expected %0d",
                                addr[15:0], i_b.resp, exp_resp[1:0]));
            end
            rec++;
        end
    endtask

    // idle records carry the expected reset level in the data column
    task automatic check_idle();
        logic [31:0] exp_rst;
        exp_rst = field(rec, 6);
        if (field(rec, 0) != OP_IDLE) begin
            report_problem($sformatf("idle mark but record %0d is no idle", rec));
        end else begin
            checks++;
            if (i_reconfig_reset !== exp_rst[0]) begin
                report_mismatch($sformatf("o_reconfig_reset is %b, expected %b",
                                i_reconfig_reset, exp_rst[0]));
            end
            rec++;
        end
    endtask

    // --------------------------------------------------
    // bus watch
    // --------------------------------------------------
    always @(negedge i_clk) begin
        // bus quiet while held in reset
        if (i_reconfig_reset === 1'b1 && (i_ready != '0 || i_r.valid || i_b.valid)) begin
            report_mismatch("ready or response valid while o_reconfig_reset is high");
        end
        // stalled responses must not move
        if (r_held && (!i_r.valid || i_r.data != r_last.data || i_r.resp != r_last.resp)) begin
            report_mismatch("read response changed under back-pressure");
        end
        if (b_held && (!i_b.valid || i_b.resp != b_last.resp)) begin
            report_mismatch("write response changed under back-pressure");
        end
        r_held = i_r.valid && !i_rready;
        b_held = i_b.valid && !i_bready;
        r_last = i_r;
        b_last = i_b;
        if (i_r.valid && i_rready) begin
            check_read();
        end
        if (i_b.valid && i_bready) begin
            check_write();
        end
        if (i_idle_mark) begin
            check_idle();
        end
        // anything left over never completed
        if (i_finish && !done) begin
            done = 1'b1;
            if (field(rec, 0) <= OP_WRITE) begin
                report_problem($sformatf("record %0d and later never completed", rec));
            end
        end
    end

endmodule

// ==== sim/tb_eth_ctrl_top.sv ====
/*
 * Testbench top for the management controller. Replays sim/eth_ctrl_stim.txt
 * one AXI4-Lite transaction at a time. Run from the project root.
 */
`include "eth_ctrl_consts.svh"

module tb_eth_ctrl_top
    import eth_ctrl_bus_pkg::*;
    import eth_ctrl_port_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_W      = 8;
    localparam int MAX_REC    = 64;
    localparam int OP_IDLE    = 0;
    localparam int OP_READ    = 1;
    localparam int OP_WRITE   = 2;
    localparam int WAIT_LIMIT = 200;
    // events the driver can wait for
    localparam int EV_AR      = 0;
    localparam int EV_AW      = 1;
    localparam int EV_R       = 2;
    localparam int EV_B       = 3;

    logic             clk;
    logic             rst;
    logic             soft_reset;
    port_status_vec_t port_status;
    axi_aw_t          aw;
    axi_w_t           w;
    axi_ar_t          ar;
    logic             rready;
    logic             bready;
    axi_ready_t       ready;
    axi_r_t           r;
    axi_b_t           b;
    logic             reconfig_reset;
    logic             idle_mark;
    logic             finish_req;
    int               errors;
    int               checks;
    int               timeouts;
    int               ops_run;
    logic [31:0]      lcg_state;
    logic [31:0]      stim [0:REC_W*MAX_REC-1];

    eth_ctrl_top u_eth_ctrl_top (
        .i_reconfig_clk   (clk),
        .i_rst            (rst),
        .i_soft_reset     (soft_reset),
        .i_port_status    (port_status),
        .i_aw             (aw),
        .i_w              (w),
        .i_ar             (ar),
        .i_rready         (rready),
        .i_bready         (bready),
        .o_ready          (ready),
        .o_r              (r),
        .o_b              (b),
        .o_reconfig_reset (reconfig_reset)
    );

    tb_eth_ctrl_checker u_checker (
        .i_clk            (clk),
        .i_reconfig_reset (reconfig_reset),
        .i_ready          (ready),
        .i_r              (r),
        .i_b              (b),
        .i_rready         (rready),
        .i_bready         (bready),
        .i_idle_mark      (idle_mark),
        .i_finish         (finish_req),
        .o_errors         (errors),
        .o_checks         (checks)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // --------------------------------------------------
    // random rready / bready back-pressure
    // --------------------------------------------------
    initial begin
        rready    = 1'b0;
        bready    = 1'b0;
        lcg_state = 32'h1c3a;
        forever begin
            @(posedge clk);
            #1;
            lcg_state = lcg_next(lcg_state);
            // high about three cycles in four
            rready = |lcg_state[17:16];
            bready = |lcg_state[19:18];
        end
    end

    function automatic logic event_seen(input int what);
        case (what)
            EV_AR:   return ready.ar;
            EV_AW:   return ready.aw && ready.w;
            EV_R:    return r.valid && rready;
            EV_B:    return b.valid && bready;
            default: return 1'b0;
        endcase
    endfunction

    // sampled at negedge so the transfer lands on the next rising edge
    task automatic wait_event(input int what, input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!event_seen(what) && n < WAIT_LIMIT);
        if (!event_seen(what)) begin
            $display("timeout: no %s within %0d cycles at %0t ns", name, WAIT_LIMIT, $time);
            timeouts++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_read(input logic [`ETH_ADDR_W-1:0] addr);
        ar.addr  = addr;
        ar.valid = 1'b1;
        wait_event(EV_AR, "read address ready");
        ar.valid = 1'b0;
        if (timeouts == 0) begin
            wait_event(EV_R, "read response");
        end
    endtask

    task automatic run_write(input logic [`ETH_ADDR_W-1:0] addr,
                             input logic [`ETH_DATA_W-1:0] data,
                             input logic [`ETH_STRB_W-1:0] strb);
        aw.addr  = addr;
        aw.valid = 1'b1;
        w.data   = data;
        w.strb   = strb;
        w.valid  = 1'b1;
        wait_event(EV_AW, "write address/data ready");
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        if (timeouts == 0) begin
            wait_event(EV_B, "write response");
        end
    endtask

    // idle records mark a point for the reset check
    // requests are raised while the bus should sit in reset
    task automatic run_idle(input logic in_reset);
        if (in_reset) begin
            ar.valid = 1'b1;
            aw.valid = 1'b1;
            w.valid  = 1'b1;
        end
        idle_mark = 1'b1;
        @(posedge clk);
        #1;
        idle_mark = 1'b0;
        ar.valid  = 1'b0;
        aw.valid  = 1'b0;
        w.valid   = 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int          op;
        logic [31:0] addr_word;
        rst         = 1'b1;
        soft_reset  = 1'b0;
        port_status = '0;
        aw          = '0;
        w           = '0;
        ar          = '0;
        idle_mark   = 1'b0;
        finish_req  = 1'b0;
        timeouts    = 0;
        ops_run     = 0;
        $readmemh("sim/eth_ctrl_stim.txt", stim);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int rec = 0; rec < MAX_REC; rec++) begin
            op        = stim[REC_W*rec];
            addr_word = stim[REC_W*rec + 1];
            if (op > OP_WRITE || op < OP_IDLE || timeouts != 0) begin
                break;
            end
            // apply status and let it settle through the synchronizers
            port_status = stim[REC_W*rec + 4][15:0];
            wait_cycles(stim[REC_W*rec + 5]);
            case (op)
                OP_READ:  run_read(addr_word[`ETH_ADDR_W-1:0]);
                OP_WRITE: run_write(addr_word[`ETH_ADDR_W-1:0], stim[REC_W*rec + 2],
                                    stim[REC_W*rec + 3][`ETH_STRB_W-1:0]);
                default:  run_idle(stim[REC_W*rec + 6][0]);
            endcase
            ops_run++;
        end
        finish_req = 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (ops_run == 0) begin
            $display("no records were read from sim/eth_ctrl_stim.txt");
        end
        $display("records=%0d checks=%0d errors=%0d timeouts=%0d",
                 ops_run, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && ops_run > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/eth_ctrl_stim.txt ====
// op(0 idle 1 read 2 write 3 end) addr wdata strb status settle exp_data exp_resp
// all hex; idle rows expect the o_reconfig_reset level in exp_data
0 0000 00000000 0 0000 14 00000001 0
0 0000 00000000 0 4444 0A 00000000 0
1 0000 00000000 F FFFF 06 45540104 0
1 0010 00000000 F FFFF 00 00000000 2
2 0020 12345678 F FFFF 00 00000000 2
2 0000 DEADBEEF F FFFF 00 00000000 0
1 0000 00000000 F FFFF 00 45540104 0
2 0004 11223344 F FFFF 00 00000000 0
1 0004 00000000 F FFFF 00 11223344 0
2 0004 AABBCCDD 5 FFFF 00 00000000 0
1 0004 00000000 F FFFF 00 11BB33DD 0
2 0004 55667788 A FFFF 00 00000000 0
1 0004 00000000 F FFFF 00 55BB77DD 0
1 0008 00000000 F FFFF 02 00FFFF0F 0
1 000C 00000000 F FFFF 00 00000000 0
1 0008 00000000 F 7EBF 06 007EBF02 0
1 0008 00000000 F FFDF 06 00FFDF0D 0
1 000C 00000000 F FFDF 00 00000002 0
1 000C 00000000 F FFFF 06 00000002 0
2 000C 00000002 F FFFF 00 00000000 0
1 000C 00000000 F FFFF 00 00000000 0
1 0000 00000000 F FFFF 00 45540104 0
2 0004 00000000 1 FFFF 00 00000000 0
1 0004 00000000 F FFFF 00 55BB7700 0
3 0000 00000000 0 0000 00 00000000 0

// ==== filelist.f ====
+incdir+verilog
verilog/eth_ctrl_bus_pkg.sv
verilog/eth_ctrl_port_pkg.sv
verilog/reconfig_reset_seq.sv
verilog/port_status_sync.sv
verilog/axi_lite_avmm_bridge.sv
verilog/port_csr.sv
verilog/eth_ctrl_top.sv
sim/tb_eth_ctrl_checker.sv
sim/tb_eth_ctrl_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_eth_ctrl_top
FILELIST   := filelist.f
MDIR       := obj_dir
COMMON     := --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --assert -j 0 --Mdir $(MDIR)
PASS_MSG   := TEST OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
